// ==== src/exec_pkg.sv ====
package exec_pkg;

  // --------------------
  // widths
  typedef logic [31:0] word_t;      // data, address or pc
  typedef logic [4:0]  reg_addr_t;  // x0 reads as zero
  typedef logic [4:0]  exec_op_t;

  // --------------------
  // operation codes
  localparam exec_op_t op_add   = 5'd0;
  localparam exec_op_t op_sub   = 5'd1;
  localparam exec_op_t op_and   = 5'd2;
  localparam exec_op_t op_or    = 5'd3;
  localparam exec_op_t op_xor   = 5'd4;
  localparam exec_op_t op_sll   = 5'd5;
  localparam exec_op_t op_srl   = 5'd6;
  localparam exec_op_t op_sra   = 5'd7;
  localparam exec_op_t op_slt   = 5'd8;
  localparam exec_op_t op_sltu  = 5'd9;
  localparam exec_op_t op_lui   = 5'd10;
  localparam exec_op_t op_auipc = 5'd11;
  localparam exec_op_t op_jal   = 5'd12;
  localparam exec_op_t op_jalr  = 5'd13;
  localparam exec_op_t op_beq   = 5'd14;
  localparam exec_op_t op_bne   = 5'd15;
  localparam exec_op_t op_blt   = 5'd16;
  localparam exec_op_t op_bge   = 5'd17;
  localparam exec_op_t op_load  = 5'd18;
  localparam exec_op_t op_store = 5'd19;
  localparam exec_op_t op_divu  = 5'd20;
  localparam exec_op_t op_remu  = 5'd21;

  // --------------------
  // divider sequencing
  typedef enum logic [1:0] {
    div_idle,
    div_busy,
    div_done
  } div_state_t;

  localparam word_t word_zero = 32'h0000_0000;

endpackage

// ==== src/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
  input  exec_pkg::exec_op_t op,
  input  exec_pkg::word_t    a,
  input  exec_pkg::word_t    b,
  output exec_pkg::word_t    result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      exec_pkg::op_add:  result = a + b;
      exec_pkg::op_sub:  result = a - b;
      exec_pkg::op_and:  result = a & b;
      exec_pkg::op_or:   result = a | b;
      exec_pkg::op_xor:  result = a ^ b;
      exec_pkg::op_sll:  result = a << shamt;
      exec_pkg::op_srl:  result = a >> shamt;
      exec_pkg::op_sra:  result = exec_pkg::word_t'($signed(a) >>> shamt);
      exec_pkg::op_slt:  result = {31'b0, lt_signed};
      exec_pkg::op_sltu: result = {31'b0, lt_unsigned};
      default:           result = exec_pkg::word_zero;  // not an alu op
    endcase
  end

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
  input  exec_pkg::exec_op_t op,
  input  exec_pkg::word_t    a,
  input  exec_pkg::word_t    b,
  output logic               taken
);

  logic equal;
  logic less;

  assign equal = a == b;
  assign less  = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      exec_pkg::op_beq:  taken = equal;
      exec_pkg::op_bne:  taken = !equal;
      exec_pkg::op_blt:  taken = less;
      exec_pkg::op_bge:  taken = !less;
      exec_pkg::op_jal,
      exec_pkg::op_jalr: taken = 1'b1;  // jumps always redirect
      default:           taken = 1'b0;
    endcase
  end

endmodule

// ==== src/address_gen.sv ====
`timescale 1ns/1ps

module address_gen (
  input  exec_pkg::exec_op_t op,
  input  exec_pkg::word_t    pc,
  input  exec_pkg::word_t    a,
  input  exec_pkg::word_t    imm,
  output exec_pkg::word_t    address,
  output exec_pkg::word_t    target,
  output logic               misaligned
);

  logic            reg_based;
  logic            is_mem;
  logic            is_flow;
  exec_pkg::word_t base;

  assign reg_based = op == exec_pkg::op_load || op == exec_pkg::op_store ||
                     op == exec_pkg::op_jalr;
  assign is_mem    = op == exec_pkg::op_load || op == exec_pkg::op_store;
  assign is_flow   = op == exec_pkg::op_jal || op == exec_pkg::op_jalr ||
                     op == exec_pkg::op_beq || op == exec_pkg::op_bne ||
                     op == exec_pkg::op_blt || op == exec_pkg::op_bge;

  assign base    = reg_based ? a : pc;
  assign address = base + imm;
  assign target  = (op == exec_pkg::op_jalr) ? {address[31:1], 1'b0} : address;

  // branches report here regardless of outcome, caller masks with taken
  always_comb begin
    if (is_mem) begin
      misaligned = address[1:0] != 2'b00;
    end else if (is_flow) begin
      misaligned = target[1];
    end else begin
      misaligned = 1'b0;
    end
  end

endmodule

// ==== src/serial_divider.sv ====
`timescale 1ns/1ps

module serial_divider #(
  parameter int div_bits = 1
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            start,
  input  logic            hold,
  input  exec_pkg::word_t dividend,
  input  exec_pkg::word_t divisor,
  output exec_pkg::word_t quotient,
  output exec_pkg::word_t remainder,
  output logic            done
);

  localparam int steps = 32 / div_bits;

  exec_pkg::div_state_t state;
  logic [5:0]           count;
  exec_pkg::word_t      rem_q;
  exec_pkg::word_t      quo_q;
  exec_pkg::word_t      div_q;
  exec_pkg::word_t      rem_n;
  exec_pkg::word_t      quo_n;
  logic [32:0]          trial;

  // restoring steps, div_bits per cycle
  // a zero divisor always subtracts, giving all ones and rem = dividend
  always_comb begin
    rem_n = rem_q;
    quo_n = quo_q;
    trial = '0;
    for (int i = 0; i < div_bits; i++) begin
      trial = {rem_n, quo_n[31]};
      quo_n = {quo_n[30:0], 1'b0};
      if (trial >= {1'b0, div_q}) begin
        trial    = trial - {1'b0, div_q};
        quo_n[0] = 1'b1;
      end
      rem_n = trial[31:0];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= exec_pkg::div_idle;
      count <= 6'd0;
    end else if (!hold) begin
      case (state)
        exec_pkg::div_idle: begin
          if (start) begin
            state <= exec_pkg::div_busy;
            count <= 6'(steps);
          end
        end
        exec_pkg::div_busy: begin
          count <= count - 6'd1;
          if (count == 6'd1) begin
            state <= exec_pkg::div_done;
          end
        end
        default: begin
          if (!start) begin
            state <= exec_pkg::div_idle;  // result consumed
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      if (state == exec_pkg::div_idle && start) begin
        rem_q <= exec_pkg::word_zero;
        quo_q <= dividend;
        div_q <= divisor;
      end else if (state == exec_pkg::div_busy) begin
        rem_q <= rem_n;
        quo_q <= quo_n;
      end
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;
  assign done      = state == exec_pkg::div_done;

endmodule

// ==== src/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
  input  exec_pkg::reg_addr_t rs1,
  input  exec_pkg::reg_addr_t rs2,
  input  exec_pkg::word_t     rdata1,
  input  exec_pkg::word_t     rdata2,
  input  logic                ex_valid,
  input  logic                ex_load,
  input  exec_pkg::reg_addr_t ex_rd,
  input  exec_pkg::word_t     ex_wdata,
  input  logic                wb_valid,
  input  exec_pkg::reg_addr_t wb_rd,
  input  exec_pkg::word_t     wb_data,
  output exec_pkg::word_t     op_a,
  output exec_pkg::word_t     op_b
);

  // youngest producer wins: result register, then writeback, then regfile
  function automatic exec_pkg::word_t pick(exec_pkg::reg_addr_t src,
                                           exec_pkg::word_t rdata);
    if (src == 5'd0) begin
      return exec_pkg::word_zero;
    end else if (ex_valid && !ex_load && ex_rd == src) begin
      return ex_wdata;  // load data is not known yet here
    end else if (wb_valid && wb_rd == src) begin
      return wb_data;
    end else begin
      return rdata;
    end
  endfunction

  always_comb begin
    op_a = pick(rs1, rdata1);
    op_b = pick(rs2, rdata2);
  end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage #(
  parameter int div_bits = 1
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  exec_pkg::exec_op_t  in_op,
  input  logic                in_use_imm,
  input  exec_pkg::word_t     in_pc,
  input  exec_pkg::word_t     in_imm,
  input  exec_pkg::reg_addr_t in_rd,
  input  exec_pkg::word_t     op_a,
  input  exec_pkg::word_t     op_b,
  input  logic                mem_stall,
  output logic                stall,
  output logic                out_valid,
  output exec_pkg::reg_addr_t out_rd,
  output exec_pkg::word_t     out_wdata,
  output exec_pkg::word_t     out_address,
  output exec_pkg::word_t     out_store_data,
  output logic                out_load,
  output logic                out_store,
  output logic                out_redirect,
  output exec_pkg::word_t     out_target,
  output logic                out_misaligned
);

  exec_pkg::word_t b_sel;
  exec_pkg::word_t alu_result;
  exec_pkg::word_t address;
  exec_pkg::word_t target;
  exec_pkg::word_t quotient;
  exec_pkg::word_t remainder;
  exec_pkg::word_t result;
  logic            taken;
  logic            agu_misaligned;
  logic            div_done;
  logic            div_ack_q;  // result taken last cycle, divider must go idle
  logic            is_load;
  logic            is_store;
  logic            is_div;
  logic            squash;
  logic            div_req;
  logic            exc;
  logic            fire;

  assign b_sel = in_use_imm ? in_imm : op_b;

  int_alu u_alu (.op(in_op), .a(op_a), .b(b_sel), .result(alu_result));

  branch_unit u_branch (.op(in_op), .a(op_a), .b(op_b), .taken(taken));

  address_gen u_agu (
    .op(in_op), .pc(in_pc), .a(op_a), .imm(in_imm),
    .address(address), .target(target), .misaligned(agu_misaligned)
  );

  serial_divider #(.div_bits(div_bits)) u_div (
    .clock(clock), .reset(reset), .start(div_req & ~div_ack_q), .hold(mem_stall),
    .dividend(op_a), .divisor(op_b),
    .quotient(quotient), .remainder(remainder), .done(div_done)
  );

  // --------------------
  // control
  assign is_load  = in_op == exec_pkg::op_load;
  assign is_store = in_op == exec_pkg::op_store;
  assign is_div   = in_op == exec_pkg::op_divu || in_op == exec_pkg::op_remu;
  assign squash   = out_valid & out_redirect;  // shadow of a taken jump
  assign div_req  = in_valid & is_div & ~squash;
  assign stall    = mem_stall | (div_req & ~(div_done & ~div_ack_q));
  assign fire     = in_valid & ~stall & ~squash;
  assign exc      = agu_misaligned & (is_load | is_store | taken);

  always_comb begin
    case (in_op)
      exec_pkg::op_lui:   result = in_imm;
      exec_pkg::op_auipc: result = address;
      exec_pkg::op_jal,
      exec_pkg::op_jalr:  result = in_pc + 32'd4;  // link address
      exec_pkg::op_divu:  result = quotient;
      exec_pkg::op_remu:  result = remainder;
      default:            result = alu_result;
    endcase
  end

  // --------------------
  // result register
  always_ff @(posedge clock) begin
    if (!reset) begin
      out_valid      <= 1'b0;
      out_load       <= 1'b0;
      out_store      <= 1'b0;
      out_redirect   <= 1'b0;
      out_misaligned <= 1'b0;
      div_ack_q      <= 1'b0;
    end else if (!mem_stall) begin
      out_valid      <= fire;
      out_load       <= fire & is_load & ~exc;
      out_store      <= fire & is_store & ~exc;
      out_redirect   <= fire & taken & ~exc;
      out_misaligned <= fire & exc;
      div_ack_q      <= fire & is_div;
    end
  end

  always_ff @(posedge clock) begin
    if (!mem_stall) begin
      out_rd         <= exc ? 5'd0 : in_rd;
      out_wdata      <= result;
      out_address    <= address;
      out_store_data <= op_b;
      out_target     <= target;
    end
  end

endmodule

// ==== src/execute_top.sv ====
`timescale 1ns/1ps

module execute_top #(
  parameter int div_bits = 2
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  exec_pkg::exec_op_t  in_op,
  input  logic                in_use_imm,
  input  exec_pkg::word_t     in_pc,
  input  exec_pkg::word_t     in_imm,
  input  exec_pkg::reg_addr_t in_rs1,
  input  exec_pkg::reg_addr_t in_rs2,
  input  exec_pkg::reg_addr_t in_rd,
  input  exec_pkg::word_t     in_rdata1,
  input  exec_pkg::word_t     in_rdata2,
  input  logic                wb_valid,
  input  exec_pkg::reg_addr_t wb_rd,
  input  exec_pkg::word_t     wb_data,
  input  logic                mem_stall,
  output logic                out_valid,
  output exec_pkg::reg_addr_t out_rd,
  output exec_pkg::word_t     out_wdata,
  output exec_pkg::word_t     out_address,
  output exec_pkg::word_t     out_store_data,
  output logic                out_load,
  output logic                out_store,
  output logic                out_redirect,
  output exec_pkg::word_t     out_target,
  output logic                out_misaligned,
  output logic                stall
);

  exec_pkg::word_t op_a;
  exec_pkg::word_t op_b;

  operand_forward u_fwd (
    .rs1(in_rs1), .rs2(in_rs2), .rdata1(in_rdata1), .rdata2(in_rdata2),
    .ex_valid(out_valid), .ex_load(out_load), .ex_rd(out_rd), .ex_wdata(out_wdata),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
    .op_a(op_a), .op_b(op_b)
  );

  execute_stage #(.div_bits(div_bits)) u_exec (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_op(in_op), .in_use_imm(in_use_imm),
    .in_pc(in_pc), .in_imm(in_imm), .in_rd(in_rd),
    .op_a(op_a), .op_b(op_b), .mem_stall(mem_stall), .stall(stall),
    .out_valid(out_valid), .out_rd(out_rd), .out_wdata(out_wdata),
    .out_address(out_address), .out_store_data(out_store_data),
    .out_load(out_load), .out_store(out_store), .out_redirect(out_redirect),
    .out_target(out_target), .out_misaligned(out_misaligned)
  );

endmodule

// ==== test/execute_chk.sv ====
`timescale 1ns/1ps

module execute_chk (
  input logic                clock,
  input logic                reset,
  input logic                mem_stall,
  input logic                out_valid,
  input logic                stall,
  input logic                out_misaligned,
  input logic                out_load,
  input logic                out_store,
  input exec_pkg::word_t     out_wdata,
  input exec_pkg::reg_addr_t out_rd
);

  // quiet outputs through reset
  quiet_in_reset: assert property (@(posedge clock)
    !reset && $past(!reset) |-> !out_valid && !stall)
    else $error("out_valid or stall high during reset");

  // an exception kills the memory access
  exc_kills_mem: assert property (@(posedge clock) disable iff (!reset)
    out_misaligned |-> !out_load && !out_store)
    else $error("misaligned access still marked as load or store");

  // back-pressure freezes the result register
  hold_on_stall: assert property (@(posedge clock) disable iff (!reset)
    mem_stall |=> $stable(out_wdata) && $stable(out_rd))
    else $error("result register changed under mem_stall");

endmodule

bind execute_top execute_chk chk (
  .clock(clock), .reset(reset), .mem_stall(mem_stall), .out_valid(out_valid),
  .stall(stall), .out_misaligned(out_misaligned), .out_load(out_load),
  .out_store(out_store), .out_wdata(out_wdata), .out_rd(out_rd)
);

// ==== test/execute_tb.sv ====
`timescale 1ns/1ps

module execute_tb;

  localparam int div_bits = 2;

  typedef struct {
    exec_pkg::exec_op_t  op;
    logic                use_imm;
    exec_pkg::word_t     pc;
    exec_pkg::word_t     imm;
    exec_pkg::reg_addr_t rs1;
    exec_pkg::reg_addr_t rs2;
    exec_pkg::reg_addr_t rd;
    exec_pkg::word_t     rdata1;
    exec_pkg::word_t     rdata2;
    logic                wb_valid;
    exec_pkg::reg_addr_t wb_rd;
    exec_pkg::word_t     wb_data;
    int                  hold;
    logic                squashed;
    exec_pkg::reg_addr_t e_rd;
    exec_pkg::word_t     e_wdata;
    exec_pkg::word_t     e_addr;
    exec_pkg::word_t     e_sdata;
    exec_pkg::word_t     e_target;
    logic                e_load;
    logic                e_store;
    logic                e_redirect;
    logic                e_mis;
  } row_t;

  logic clock = 1'b0;
  logic reset;
  logic in_valid, in_use_imm, wb_valid, mem_stall;
  exec_pkg::exec_op_t  in_op;
  exec_pkg::word_t     in_pc, in_imm, in_rdata1, in_rdata2, wb_data;
  exec_pkg::reg_addr_t in_rs1, in_rs2, in_rd, wb_rd;
  logic                out_valid, out_load, out_store, out_redirect, out_misaligned, stall;
  exec_pkg::reg_addr_t out_rd;
  exec_pkg::word_t     out_wdata, out_address, out_store_data, out_target;

  row_t rows[$];
  row_t expq[$];
  int   errors = 0;

  execute_top #(.div_bits(div_bits)) dut (.*);

  always #50 clock = ~clock;

  task automatic fail_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic compare_field(input string name, input exec_pkg::word_t got,
                               input exec_pkg::word_t exp);
    assert (got === exp)
    else fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic add_row(input exec_pkg::exec_op_t op, input logic use_imm,
                         input exec_pkg::word_t pc, input exec_pkg::word_t imm,
                         input exec_pkg::reg_addr_t rs1, input exec_pkg::word_t rdata1,
                         input exec_pkg::reg_addr_t rs2, input exec_pkg::word_t rdata2,
                         input exec_pkg::reg_addr_t rd, input exec_pkg::word_t wdata);
    row_t r;
    r = '{op: op, use_imm: use_imm, pc: pc, imm: imm, rs1: rs1, rs2: rs2, rd: rd,
          rdata1: rdata1, rdata2: rdata2, wb_rd: 5'd0, e_rd: rd, e_wdata: wdata,
          default: '0};
    rows.push_back(r);
  endtask

  task automatic set_wb(input exec_pkg::reg_addr_t rd, input exec_pkg::word_t data);
    rows[rows.size() - 1].wb_valid = 1'b1;
    rows[rows.size() - 1].wb_rd    = rd;
    rows[rows.size() - 1].wb_data  = data;
  endtask

  task automatic set_flow(input exec_pkg::word_t target);
    rows[rows.size() - 1].e_redirect = 1'b1;
    rows[rows.size() - 1].e_target   = target;
  endtask

  task automatic set_mem(input logic load, input exec_pkg::word_t addr,
                         input exec_pkg::word_t sdata);
    rows[rows.size() - 1].e_load  = load;
    rows[rows.size() - 1].e_store = !load;
    rows[rows.size() - 1].e_addr  = addr;
    rows[rows.size() - 1].e_sdata = sdata;
  endtask

  task automatic set_mis();
    rows[rows.size() - 1].e_mis = 1'b1;
    rows[rows.size() - 1].e_rd  = 5'd0;
  endtask

  // --------------------
  // stimulus table
  task automatic build_table();
    add_row(exec_pkg::op_add, 0, 32'h0, 32'h0, 2, 32'h5, 3, 32'h7, 1, 32'hc);
    add_row(exec_pkg::op_sub, 0, 32'h4, 32'h0, 1, 32'h63, 5, 32'h2, 4, 32'ha);  // bypass x1
    add_row(exec_pkg::op_and, 1, 32'h8, 32'hff, 7, 32'h1234, 0, 32'h0, 6, 32'h34);
    add_row(exec_pkg::op_or, 0, 32'hc, 32'h0, 9, 32'h0, 10, 32'h1, 8, 32'h101);
    set_wb(9, 32'h100);
    rows[rows.size() - 1].hold = 2;
    add_row(exec_pkg::op_xor, 0, 32'h10, 32'h0, 8, 32'h0, 12, 32'hf0, 11, 32'h1f1);
    set_wb(8, 32'hffff);  // result register wins
    add_row(exec_pkg::op_sll, 1, 32'h14, 32'h4, 14, 32'h1, 0, 32'h0, 13, 32'h10);
    rows[rows.size() - 1].hold = 1;
    add_row(exec_pkg::op_srl, 0, 32'h18, 32'h0, 16, 32'h8000_0000, 17, 32'h23, 15,
            32'h1000_0000);
    add_row(exec_pkg::op_sra, 1, 32'h1c, 32'h4, 2, 32'h8000_0000, 0, 32'h0, 18,
            32'hf800_0000);
    add_row(exec_pkg::op_slt, 0, 32'h20, 32'h0, 3, 32'hffff_fffe, 4, 32'h1, 19, 32'h1);
    add_row(exec_pkg::op_sltu, 0, 32'h24, 32'h0, 3, 32'hffff_fffe, 4, 32'h1, 20, 32'h0);
    add_row(exec_pkg::op_add, 1, 32'h28, 32'h5, 0, 32'hdead, 0, 32'h0, 21, 32'h5);
    add_row(exec_pkg::op_lui, 1, 32'h2c, 32'h1234_5000, 0, 32'h0, 0, 32'h0, 22,
            32'h1234_5000);
    add_row(exec_pkg::op_auipc, 1, 32'h100, 32'h2000, 0, 32'h0, 0, 32'h0, 23, 32'h2100);
    add_row(exec_pkg::op_beq, 0, 32'h200, 32'h40, 24, 32'h7, 25, 32'h7, 0, 32'h0);
    set_flow(32'h240);
    add_row(exec_pkg::op_add, 0, 32'h204, 32'h0, 2, 32'h1, 3, 32'h1, 26, 32'h2);
    rows[rows.size() - 1].squashed = 1'b1;
    add_row(exec_pkg::op_bne, 0, 32'h300, 32'h20, 26, 32'h3, 27, 32'h3, 0, 32'h0);
    add_row(exec_pkg::op_add, 0, 32'h304, 32'h0, 28, 32'h1, 29, 32'h2, 27, 32'h3);
    add_row(exec_pkg::op_jal, 1, 32'h400, 32'h100, 0, 32'h0, 0, 32'h0, 1, 32'h404);
    set_flow(32'h500);
    add_row(exec_pkg::op_add, 0, 32'h404, 32'h0, 2, 32'h1, 3, 32'h1, 4, 32'h2);
    rows[rows.size() - 1].squashed = 1'b1;
    add_row(exec_pkg::op_jalr, 1, 32'h500, 32'h10, 3, 32'h1001, 0, 32'h0, 2, 32'h504);
    set_flow(32'h1010);
    add_row(exec_pkg::op_add, 0, 32'h504, 32'h0, 2, 32'h1, 3, 32'h1, 4, 32'h2);
    rows[rows.size() - 1].squashed = 1'b1;
    add_row(exec_pkg::op_blt, 0, 32'h600, 32'h8, 4, 32'hffff_fffb, 5, 32'h2, 0, 32'h0);
    set_flow(32'h608);
    add_row(exec_pkg::op_add, 0, 32'h604, 32'h0, 2, 32'h1, 3, 32'h1, 4, 32'h2);
    rows[rows.size() - 1].squashed = 1'b1;
    add_row(exec_pkg::op_bge, 0, 32'h700, 32'h8, 6, 32'h1, 7, 32'h2, 0, 32'h0);
    add_row(exec_pkg::op_load, 1, 32'h704, 32'h24, 6, 32'h1000, 0, 32'h0, 5, 32'h0);
    set_mem(1'b1, 32'h1024, 32'h0);
    add_row(exec_pkg::op_store, 1, 32'h708, 32'h8, 7, 32'h2000, 8, 32'hcafe_f00d, 0, 32'h0);
    set_mem(1'b0, 32'h2008, 32'hcafe_f00d);
    rows[rows.size() - 1].hold = 3;
    add_row(exec_pkg::op_load, 1, 32'h70c, 32'h2, 6, 32'h1000, 0, 32'h0, 9, 32'h0);
    set_mis();
    add_row(exec_pkg::op_jal, 1, 32'h700, 32'h102, 0, 32'h0, 0, 32'h0, 1, 32'h0);
    set_mis();
    add_row(exec_pkg::op_divu, 0, 32'h800, 32'h0, 20, 32'd100, 21, 32'd7, 10, 32'he);
    rows[rows.size() - 1].hold = 2;
    add_row(exec_pkg::op_remu, 0, 32'h804, 32'h0, 13, 32'd100, 12, 32'd7, 11, 32'h2);
    add_row(exec_pkg::op_divu, 0, 32'h808, 32'h0, 22, 32'h1234, 0, 32'h5, 12, 32'hffff_ffff);
    add_row(exec_pkg::op_remu, 0, 32'h80c, 32'h0, 22, 32'h1234, 23, 32'h0, 13, 32'h1234);
    add_row(exec_pkg::op_add, 0, 32'h810, 32'h0, 15, 32'h10, 16, 32'h20, 14, 32'h30);
    rows[rows.size() - 1].hold = 2;
  endtask

  // presents one row with its mem_stall cycles split before and during it
  task automatic apply_row(input row_t r);
    int pre;
    int left;
    int waits;
    pre  = (r.hold > 0) ? $urandom_range(r.hold, 0) : 0;
    left = r.hold - pre;
    repeat (pre) begin
      in_valid  <= 1'b0;
      wb_valid  <= 1'b0;
      mem_stall <= 1'b1;
      @(posedge clock);
    end
    in_valid   <= 1'b1;
    in_op      <= r.op;
    in_use_imm <= r.use_imm;
    in_pc      <= r.pc;
    in_imm     <= r.imm;
    in_rs1     <= r.rs1;
    in_rs2     <= r.rs2;
    in_rd      <= r.rd;
    in_rdata1  <= r.rdata1;
    in_rdata2  <= r.rdata2;
    wb_valid   <= r.wb_valid;
    wb_rd      <= r.wb_rd;
    wb_data    <= r.wb_data;
    waits      = 0;
    do begin
      mem_stall <= left > 0;
      if (left > 0) left--;
      @(posedge clock);
      if (stall) waits++;
    end while (stall);  // accepted at the first edge with stall low
    // the quotient needs 32 / div_bits busy cycles on top of any mem_stall
    if (r.op == exec_pkg::op_divu || r.op == exec_pkg::op_remu) begin
      assert (waits >= r.hold - pre + 32 / div_bits)
      else fail_run("a divide was accepted before its quotient could be ready");
    end
    if (!r.squashed) expq.push_back(r);
  endtask

  // --------------------
  // in-order result check when downstream takes the result
  always @(posedge clock) begin
    row_t e;
    if (reset && mem_stall) compare_field("stall", stall, 1'b1);
    if (reset && out_valid && !mem_stall) begin
      if (expq.size() == 0) begin
        fail_run("a result appeared on out_valid when none was expected");
      end else begin
        e = expq.pop_front();
        compare_field("out_rd", out_rd, e.e_rd);
        if (e.e_rd != 5'd0 && !e.e_load) compare_field("out_wdata", out_wdata, e.e_wdata);
        compare_field("out_load", out_load, e.e_load);
        compare_field("out_store", out_store, e.e_store);
        compare_field("out_redirect", out_redirect, e.e_redirect);
        compare_field("out_misaligned", out_misaligned, e.e_mis);
        if (e.e_load || e.e_store) compare_field("out_address", out_address, e.e_addr);
        if (e.e_store) compare_field("out_store_data", out_store_data, e.e_sdata);
        if (e.e_redirect) compare_field("out_target", out_target, e.e_target);
      end
    end
  end

  initial begin
    void'($urandom(68018));
    reset = 1'b0;
    in_valid = 1'b0;
    in_op = exec_pkg::op_add;
    in_use_imm = 1'b0;
    in_pc = exec_pkg::word_zero;
    in_imm = exec_pkg::word_zero;
    in_rs1 = 5'd0;
    in_rs2 = 5'd0;
    in_rd = 5'd0;
    in_rdata1 = exec_pkg::word_zero;
    in_rdata2 = exec_pkg::word_zero;
    wb_valid = 1'b0;
    wb_rd = 5'd0;
    wb_data = exec_pkg::word_zero;
    mem_stall = 1'b0;
    build_table();
    fork
      begin
        repeat (rows.size() * 40) @(posedge clock);
        fail_run("timeout: the results did not drain in time");
      end
    join_none
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    foreach (rows[i]) apply_row(rows[i]);
    in_valid  <= 1'b0;
    wb_valid  <= 1'b0;
    mem_stall <= 1'b0;
    while (expq.size() != 0) @(posedge clock);
    repeat (3) @(posedge clock);  // catch any stray extra result
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
src/exec_pkg.sv
src/int_alu.sv
src/branch_unit.sv
src/address_gen.sv
src/serial_divider.sv
src/operand_forward.sv
src/execute_stage.sv
src/execute_top.sv
test/execute_chk.sv
test/execute_tb.sv

// ==== Bender.yml ====
package:
  name: execute

sources:
  - src/exec_pkg.sv
  - src/int_alu.sv
  - src/branch_unit.sv
  - src/address_gen.sv
  - src/serial_divider.sv
  - src/operand_forward.sv
  - src/execute_stage.sv
  - src/execute_top.sv
  - target: test
    files:
      - test/execute_chk.sv
      - test/execute_tb.sv
